//--- verilog/ntm_modular_pkg.sv
/* Shared word sizes, operation codes and bundled structs for the modular
   vector adder; imported by the RTL and the testbench */

package ntm_modular_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_SIZE    = 64;
  localparam int CONTROL_SIZE = 16;

  typedef logic [DATA_SIZE-1:0]    data_t;
  typedef logic [CONTROL_SIZE-1:0] index_t;

  // Add or subtract, one bit
  typedef enum logic {
    MOD_ADD = 1'b0,
    MOD_SUB = 1'b1
  } modular_op_t;

  // Host configuration, sampled with start (81 bits)
  typedef struct packed {
    data_t       modulo;
    index_t      size;
    modular_op_t operation;
  } vector_cfg_t;

  // One operand pair for the scalar unit (193 bits)
  typedef struct packed {
    modular_op_t operation;
    data_t       modulo;
    data_t       data_a;
    data_t       data_b;
  } scalar_req_t;

endpackage

//--- verilog/ntm_scalar_modular_adder.sv
/* Two-stage modular add/subtract of one reduced operand pair; ready pulses
   two cycles after start, and a new start is accepted every cycle */

module ntm_scalar_modular_adder
  import ntm_modular_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  scalar_req_t req,
  output logic        ready,
  output data_t       result
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1: raw sum or difference
  ////////////////////////////////////////////////////////////////////////////

  // One extra bit holds the carry of a sum or the borrow of a difference
  logic [DATA_SIZE:0] raw_next;
  logic [DATA_SIZE:0] raw_s1;
  logic               valid_s1;
  data_t              modulo_s1;
  modular_op_t        op_s1;

  assign raw_next = (req.operation == MOD_SUB) ?
                    ({1'b0, req.data_a} - {1'b0, req.data_b}) :
                    ({1'b0, req.data_a} + {1'b0, req.data_b});

  // Valid bit travels with the data
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= start;
    end
  end

  // Modulus and operation ride along so requests in flight stay apart
  always_ff @(posedge CLK) begin
    if (start) begin
      raw_s1    <= raw_next;
      modulo_s1 <= req.modulo;
      op_s1     <= req.operation;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2: single correction into [0, modulo)
  ////////////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE:0] minus_mod;
  data_t              corrected;

  assign minus_mod = raw_s1 - {1'b0, modulo_s1};

  always_comb begin
    corrected = raw_s1[DATA_SIZE-1:0];
    if (op_s1 == MOD_ADD) begin
      // Sum at or above modulus, subtract once
      if (raw_s1 >= {1'b0, modulo_s1}) begin
        corrected = minus_mod[DATA_SIZE-1:0];
      end
    end else if (raw_s1[DATA_SIZE]) begin
      // Borrow set, wrap back by one modulus
      corrected = raw_s1[DATA_SIZE-1:0] + modulo_s1;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= valid_s1;
    end
  end

  always_ff @(posedge CLK) begin
    if (valid_s1) begin
      result <= corrected;
    end
  end

endmodule

//--- verilog/ntm_vector_modular_adder.sv
/* Element-wise modular add/subtract of two streamed vectors; collects each
   A/B pair, runs it through the scalar unit and counts elements to the end */

module ntm_vector_modular_adder
  import ntm_modular_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  vector_cfg_t cfg,
  input  logic        data_a_in_enable,
  input  logic        data_b_in_enable,
  input  data_t       data_a_in,
  input  data_t       data_b_in,
  output logic        ready,
  output logic        data_out_enable,
  output data_t       data_out
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INPUT,
    ST_WAIT
  } state_t;

  state_t      state;
  index_t      index;
  logic        last_element;

  // Latched configuration and operands
  vector_cfg_t cfg_q;
  data_t       operand_a;
  data_t       operand_b;
  logic        flag_a;
  logic        flag_b;

  // Scalar unit hookup
  logic        start_scalar;
  logic        ready_scalar;
  scalar_req_t req;
  data_t       result_scalar;

  assign last_element = (index == cfg_q.size - index_t'(1));

  // Request stays stable while the scalar unit works
  assign req = '{
    operation: cfg_q.operation,
    modulo:    cfg_q.modulo,
    data_a:    operand_a,
    data_b:    operand_b
  };

  ////////////////////////////////////////////////////////////////////////////
  // Payload capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && start) begin
      cfg_q <= cfg;
    end
    // Each operand under its own strobe
    if (state == ST_INPUT && data_a_in_enable) begin
      operand_a <= data_a_in;
    end
    if (state == ST_INPUT && data_b_in_enable) begin
      operand_b <= data_b_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ST_IDLE;
      index           <= '0;
      flag_a          <= 1'b0;
      flag_b          <= 1'b0;
      start_scalar    <= 1'b0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
    end else begin
      // Strobes default low, single-cycle pulses
      start_scalar    <= 1'b0;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            index <= '0;
            state <= ST_INPUT;
          end
        end
        ST_INPUT: begin
          if (data_a_in_enable) begin
            flag_a <= 1'b1;
          end
          if (data_b_in_enable) begin
            flag_b <= 1'b1;
          end
          // Pair complete, hand it to the scalar unit
          if (flag_a && flag_b) begin
            start_scalar <= 1'b1;
            flag_a       <= 1'b0;
            flag_b       <= 1'b0;
            state        <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (ready_scalar) begin
            data_out        <= result_scalar;
            data_out_enable <= 1'b1;
            if (last_element) begin
              ready <= 1'b1;
              state <= ST_IDLE;
            end else begin
              index <= index + index_t'(1);
              state <= ST_INPUT;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Restarted once per element
  ntm_scalar_modular_adder scalar_adder (
    .CLK   (CLK),
    .RST   (RST),
    .start (start_scalar),
    .req   (req),
    .ready (ready_scalar),
    .result(result_scalar)
  );

endmodule

//--- verilog/ntm_modular_top.sv
/* Top level of the modular vector block; ports go straight to the vector
   adder, so latency equals that of the vector adder */

module ntm_modular_top
  import ntm_modular_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  vector_cfg_t cfg,
  input  logic        data_a_in_enable,
  input  logic        data_b_in_enable,
  input  data_t       data_a_in,
  input  data_t       data_b_in,
  output logic        ready,
  output logic        data_out_enable,
  output data_t       data_out
);

  // Element-wise A +/- B mod cfg.modulo
  ntm_vector_modular_adder vector_adder (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .cfg             (cfg),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .ready           (ready),
    .data_out_enable (data_out_enable),
    .data_out        (data_out)
  );

endmodule

//--- verification/ntm_modular_assertions.sv
/* Concurrent checks on the strobes of the vector adder; attached to every
   instance of it by the bind at the end of this file */

module ntm_modular_assertions (
  input logic CLK,
  input logic RST,
  input logic ready,
  input logic data_out_enable,
  input logic start_scalar,
  input logic ready_scalar
);

  timeunit 1ns;
  timeprecision 1ps;

  // End of vector only together with a result
  ready_with_result: assert property (
    @(posedge CLK) disable iff (RST)
    ready |-> data_out_enable
  ) else $error("ready pulsed without data_out_enable");

  // Results leave as one-cycle pulses
  result_single_pulse: assert property (
    @(posedge CLK) disable iff (RST)
    data_out_enable |=> !data_out_enable
  ) else $error("data_out_enable held high for more than one cycle");

  // Scalar unit answers exactly two cycles after its start
  scalar_latency: assert property (
    @(posedge CLK) disable iff (RST)
    $past(start_scalar, 2) |-> ready_scalar
  ) else $error("ready_scalar missing two cycles after start_scalar");

  // and never without a start
  scalar_no_spurious: assert property (
    @(posedge CLK) disable iff (RST)
    ready_scalar |-> $past(start_scalar, 2)
  ) else $error("ready_scalar without start_scalar two cycles before");

endmodule

bind ntm_vector_modular_adder ntm_modular_assertions strobe_checks (
  .CLK            (CLK),
  .RST            (RST),
  .ready          (ready),
  .data_out_enable(data_out_enable),
  .start_scalar   (start_scalar),
  .ready_scalar   (ready_scalar)
);

//--- verification/ntm_modular_tb.sv
/* Testbench for the modular vector block; streams directed and random vectors
   into the top level and checks each result, its latency and the end pulse */

module ntm_modular_tb
  import ntm_modular_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // Run limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 5;
  localparam int RANDOM_VECTORS = 10;
  localparam int MAX_LENGTH     = 12;
  // Directed vectors 5 + 4 + 4 + 4 + 1
  localparam int FIXED_ELEMENTS = 18;
  localparam int MAX_ELEMENTS   = FIXED_ELEMENTS + RANDOM_VECTORS * MAX_LENGTH;
  localparam int CYCLE_LIMIT    = 20 * MAX_ELEMENTS + RESET_CYCLES;

  logic        CLK;
  logic        RST;
  logic        start;
  vector_cfg_t cfg;
  logic        data_a_in_enable;
  logic        data_b_in_enable;
  data_t       data_a_in;
  data_t       data_b_in;
  logic        ready;
  logic        data_out_enable;
  data_t       data_out;

  // Operands of the next vector
  data_t vec_a[$];
  data_t vec_b[$];

  // Expected results in order
  data_t exp_data[$];
  logic  exp_last[$];
  int    exp_cycle[$];

  int cycle_count = 0;
  int checked     = 0;

  ntm_modular_top ntm_modular_top_inst (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .cfg             (cfg),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .ready           (ready),
    .data_out_enable (data_out_enable),
    .data_out        (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Reduced operands in, reduced result out
  function automatic data_t mod_ref(input vector_cfg_t c, input data_t a, input data_t b);
    if (c.operation == MOD_ADD) begin
      // Sum reaches the modulus once a covers the gap left by b
      if (a >= c.modulo - b) begin
        return a - (c.modulo - b);
      end
      return a + b;
    end
    if (a >= b) begin
      return a - b;
    end
    // b above a, wrap around from the modulus
    return c.modulo - (b - a);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Cycle counter and run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles, the run did not end", cycle_count));
    end
  end

  // Outputs are read at the rising edge before the DUT updates them
  always @(posedge CLK) begin
    if (!RST && ready && !data_out_enable) begin
      fail_run("ready pulsed without a result on data_out");
    end else if (!RST && data_out_enable) begin
      if (exp_data.size() == 0) begin
        fail_run("data_out_enable pulsed while no result was expected");
      end else if (exp_last[0] && !ready) begin
        fail_run("ready missing with the last result of the vector");
      end else begin
        check_data("data_out", data_out, exp_data[0]);
        check_flag("ready", ready, exp_last[0]);
        if (cycle_count != exp_cycle[0]) begin
          fail_run($sformatf("error: data_out_enable cycle got 0x%h expected 0x%h",
                             cycle_count, exp_cycle[0]));
        end
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        void'(exp_cycle.pop_front());
        checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic data_t random_below(input data_t modulo);
    return {$urandom, $urandom} % modulo;
  endfunction

  task automatic add_pair(input data_t a, input data_t b);
    vec_a.push_back(a);
    vec_b.push_back(b);
  endtask

  // One operand strobe, entered and left on a falling edge
  task automatic strobe_operand(input logic is_b, input data_t value);
    if (is_b) begin
      data_b_in_enable = 1'b1;
      data_b_in        = value;
    end else begin
      data_a_in_enable = 1'b1;
      data_a_in        = value;
    end
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // Host may go on once the current element has left
  task automatic wait_result();
    do begin
      @(negedge CLK);
    end while (data_out_enable !== 1'b1);
  endtask

  // Sends start and every queued pair, one element in flight at a time
  task automatic run_vector(input data_t modulo, input modular_op_t op);
    vector_cfg_t c;
    int          n;
    int          mode;
    int          later;
    n           = vec_a.size();
    c.modulo    = modulo;
    c.size      = index_t'(n);
    c.operation = op;
    start       = 1'b1;
    cfg         = c;
    @(negedge CLK);
    start = 1'b0;
    for (int i = 0; i < n; i++) begin
      repeat ($urandom_range(2, 0)) @(negedge CLK);
      mode = $urandom_range(2, 0);
      if (mode == 0) begin
        // Both strobes in one cycle
        data_a_in_enable = 1'b1;
        data_a_in        = vec_a[i];
        later            = cycle_count;
        strobe_operand(1'b1, vec_b[i]);
      end else begin
        strobe_operand(mode == 2, (mode == 2) ? vec_b[i] : vec_a[i]);
        repeat ($urandom_range(3, 0)) @(negedge CLK);
        later = cycle_count;
        strobe_operand(mode == 1, (mode == 1) ? vec_b[i] : vec_a[i]);
      end
      exp_data.push_back(mod_ref(c, vec_a[i], vec_b[i]));
      exp_last.push_back(i == n - 1);
      // Captured at the next edge, registered 4 edges on, read one edge later
      exp_cycle.push_back(later + 5);
      wait_result();
    end
    vec_a.delete();
    vec_b.delete();
  endtask

  initial begin
    data_t m;
    int    len;
    void'($urandom(32'hec54_b3c1));
    RST              = 1'b1;
    start            = 1'b0;
    cfg              = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in        = '0;
    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b0;

    // Small modulus, sums below, at and above it
    add_pair(64'd0, 64'd0);
    add_pair(64'd6, 64'd7);
    add_pair(64'd12, 64'd12);
    add_pair(64'd5, 64'd3);
    add_pair(64'd12, 64'd1);
    run_vector(64'd13, MOD_ADD);

    // Differences with and without wrap
    add_pair(64'd10, 64'd3);
    add_pair(64'd3, 64'd10);
    add_pair(64'd0, 64'd96);
    add_pair(64'd50, 64'd50);
    run_vector(64'd97, MOD_SUB);

    // Near 2^64, carry out of the 64-bit sum
    m = 64'hFFFF_FFFF_FFFF_FFC5;
    add_pair(m - 64'd1, m - 64'd1);
    add_pair(m - 64'd1, 64'd1);
    add_pair(m - 64'd2, 64'd1);
    add_pair(64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFC5);
    run_vector(m, MOD_ADD);
    m = 64'hFFFF_FFFF_FFFF_FFFF;
    add_pair(64'd0, m - 64'd1);
    add_pair(m - 64'd1, 64'd0);
    add_pair(64'd1, 64'd2);
    add_pair(m - 64'd1, m - 64'd1);
    run_vector(m, MOD_SUB);

    // Single element vector
    m = 64'd1_000_003;
    add_pair(random_below(m), random_below(m));
    run_vector(m, MOD_ADD);

    // Random lengths back to back, operations alternate
    for (int v = 0; v < RANDOM_VECTORS; v++) begin
      len = $urandom_range(MAX_LENGTH, 1);
      if (v % 3 == 0) begin
        m = data_t'($urandom_range(1000, 2));
      end else begin
        m = {$urandom, $urandom} | 64'd1;
      end
      for (int e = 0; e < len; e++) begin
        add_pair(random_below(m), random_below(m));
      end
      run_vector(m, (v % 2 == 0) ? MOD_SUB : MOD_ADD);
    end

    // Last result still has to reach the compare process
    repeat (2) @(negedge CLK);
    if (exp_data.size() != 0) begin
      fail_run($sformatf("%0d results never arrived", exp_data.size()));
    end else begin
      $display("%0d results checked", checked);
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- ntm_modular.f
verilog/ntm_modular_pkg.sv
verilog/ntm_scalar_modular_adder.sv
verilog/ntm_vector_modular_adder.sv
verilog/ntm_modular_top.sv
verification/ntm_modular_assertions.sv
verification/ntm_modular_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the modular vector testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module ntm_modular_tb \
  -f ntm_modular.f \
  -o ntm_modular_sim

# A fatal stop exits nonzero, the log below carries the verdict
./obj_dir/ntm_modular_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation PASSED"
